//--- sim.f
+incdir+sim
hw/rec_pkg.sv
hw/rx_byte_packer.sv
hw/rx_data_queue.sv
hw/recovery_pec.sv
hw/rec_csr_wb.sv
hw/recovery_handler.sv
sim/tb_recovery_handler.sv

//--- sim/tb_wb_tasks.svh
// Include inside the testbench module; every task starts and returns 10 ns after a rising edge
`ifndef TB_WB_TASKS_SVH
`define TB_WB_TASKS_SVH

  localparam int DRIVE_DLY = 10;
  localparam int TIMEOUT   = 200;

  // Register bit positions
  localparam int CTRL_REC_EN    = 0;
  localparam int CTRL_THLD_LSB  = 4;
  localparam int CTRL_CLEAR     = 8;
  localparam int STAT_EMPTY     = 0;
  localparam int STAT_FULL      = 1;
  localparam int STAT_LEVEL_LSB = 4;
  localparam int STAT_PEC_DONE  = 8;

  localparam logic [31:0] LCG_SEED = 32'hb49c;

  logic [31:0] lcg_state = LCG_SEED;

  function automatic logic [BYTE_W-1:0] rand_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
  endfunction

  task automatic next_slot();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic wb_access(input logic we, input logic [WB_ADR_W-1:0] adr,
                           input logic [WORD_W-1:0] wdata, output logic [WORD_W-1:0] rdata);
    int waited;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    waited   = 0;
    do begin
      next_slot();
      waited++;
      if (waited > TIMEOUT) abort_run("timeout waiting for wishbone ack");
    end while (!wb_ack);
    rdata = wb_dat_r;
    // Hold through the ack cycle, then one idle cycle
    next_slot();
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    next_slot();
  endtask

  task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [WORD_W-1:0] data);
    logic [WORD_W-1:0] unused;
    wb_access(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [WB_ADR_W-1:0] adr, output logic [WORD_W-1:0] data);
    wb_access(1'b0, adr, '0, data);
  endtask

  task automatic send_byte(input logic [BYTE_W-1:0] data, input logic flush);
    int waited;
    rx_wvalid = 1'b1;
    rx_wdata  = data;
    rx_wflush = flush;
    waited    = 0;
    while (!rx_wready) begin
      next_slot();
      waited++;
      if (waited > TIMEOUT) abort_run("timeout waiting for ctl_rx_wready_o");
    end
    next_slot();
    rx_wvalid = 1'b0;
    rx_wflush = 1'b0;
  endtask

`endif

//--- sim/tb_recovery_handler.sv
// Single clock domain; needs rec_pkg compiled first and sim/ on the include path
`timescale 1ns/10ps

module tb_recovery_handler;
  import rec_pkg::*;

  typedef logic [BYTE_W-1:0] byte_q_t[$];
  typedef logic [WORD_W-1:0] word_q_t[$];

  logic                clk;
  logic                arst_n;
  logic                rx_wvalid;
  logic [BYTE_W-1:0]   rx_wdata;
  logic                rx_wflush;
  logic                rx_wready;
  logic                bus_start;
  logic                bus_stop;
  logic                wb_cyc;
  logic                wb_stb;
  logic                wb_we;
  logic [WB_ADR_W-1:0] wb_adr;
  logic [WORD_W-1:0]   wb_dat_w;
  logic [WORD_W-1:0]   wb_dat_r;
  logic                wb_ack;
  logic                irq;

  string             chk_name[$];
  logic [WORD_W-1:0] chk_exp[$];
  logic [WORD_W-1:0] chk_act[$];

  task automatic abort_run(input string what);
    $display("ERROR: %s", what);
    $display("Result: FAILED");
    $fatal(1, "run aborted");
  endtask

  `include "tb_wb_tasks.svh"

  recovery_handler UUT (
    .clk_i           (clk),
    .arst_n_i        (arst_n),
    .ctl_rx_wvalid_i (rx_wvalid),
    .ctl_rx_wdata_i  (rx_wdata),
    .ctl_rx_wflush_i (rx_wflush),
    .ctl_rx_wready_o (rx_wready),
    .ctl_bus_start_i (bus_start),
    .ctl_bus_stop_i  (bus_stop),
    .wb_cyc_i        (wb_cyc),
    .wb_stb_i        (wb_stb),
    .wb_we_i         (wb_we),
    .wb_adr_i        (wb_adr),
    .wb_dat_i        (wb_dat_w),
    .wb_dat_o        (wb_dat_r),
    .wb_ack_o        (wb_ack),
    .irq_o           (irq)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Expected words packed LSB first with the last partial word zero padded
  function automatic word_q_t pack_ref(byte_q_t bytes);
    word_q_t           words;
    logic [WORD_W-1:0] w;
    w = '0;
    for (int i = 0; i < bytes.size(); i++) begin
      w[(i % BYTES_PER_WORD)*BYTE_W +: BYTE_W] = bytes[i];
      if ((i % BYTES_PER_WORD == BYTES_PER_WORD - 1) || (i == bytes.size() - 1)) begin
        words.push_back(w);
        w = '0;
      end
    end
    return words;
  endfunction

  // Bit serial SMBus CRC-8
  function automatic logic [BYTE_W-1:0] crc_ref(byte_q_t bytes);
    logic [BYTE_W-1:0] crc;
    logic              fb;
    crc = '0;
    foreach (bytes[i]) begin
      for (int b = BYTE_W - 1; b >= 0; b--) begin
        fb  = crc[BYTE_W-1] ^ bytes[i][b];
        crc = {crc[BYTE_W-2:0], 1'b0};
        if (fb) crc = crc ^ PEC_POLY;
      end
    end
    return crc;
  endfunction

  task automatic expect_eq(input string name, input logic [WORD_W-1:0] exp,
                           input logic [WORD_W-1:0] act);
    chk_name.push_back(name);
    chk_exp.push_back(exp);
    chk_act.push_back(act);
  endtask

  always @(posedge clk) begin : compare
    string             name;
    logic [WORD_W-1:0] exp;
    logic [WORD_W-1:0] act;
    if (chk_act.size() != 0) begin
      name = chk_name.pop_front();
      exp  = chk_exp.pop_front();
      act  = chk_act.pop_front();
      assert (act === exp)
        else begin
          $display("FAIL %s: expected 0x%08h actual 0x%08h", name, exp, act);
          $display("Result: FAILED");
          $fatal(1, "check failed");
        end
    end
  end

  task automatic wait_level(input int n);
    logic [WORD_W-1:0] st;
    int                tries;
    tries = 0;
    do begin
      wb_read(REG_STATUS, st);
      tries++;
      if (tries > TIMEOUT) abort_run("timeout waiting for queue level");
    end while (st[STAT_LEVEL_LSB +: LEVEL_W] < n);
  endtask

  task automatic wait_irq();
    int waited;
    waited = 0;
    while (!irq) begin
      next_slot();
      waited++;
      if (waited > TIMEOUT) abort_run("timeout waiting for irq_o");
    end
  endtask

  task automatic send_random(input int n, inout byte_q_t bytes);
    logic [BYTE_W-1:0] b;
    for (int i = 0; i < n; i++) begin
      b = rand_byte();
      bytes.push_back(b);
      send_byte(b, 1'b0);
    end
  endtask

  initial begin
    byte_q_t           bytes;
    word_q_t           words;
    logic [WORD_W-1:0] rd;
    logic              rdy;
    int                n;
    int                low_cnt;
    int                guard;
    arst_n    = 1'b0;
    rx_wvalid = 1'b0;
    rx_wdata  = '0;
    rx_wflush = 1'b0;
    bus_start = 1'b0;
    bus_stop  = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    arst_n = 1'b1;
    next_slot();

    // Packing
    send_random(8, bytes);
    words = pack_ref(bytes);
    wait_level(2);
    wb_read(REG_RX_DATA, rd);
    expect_eq("packing word 0", words[0], rd);
    wb_read(REG_RX_DATA, rd);
    expect_eq("packing word 1", words[1], rd);
    wb_read(REG_RX_DATA, rd);
    expect_eq("packing empty read", '0, rd);

    // Flush
    bytes.delete();
    send_random(2, bytes);
    bytes.push_back(rand_byte());
    send_byte(bytes[2], 1'b1);
    words = pack_ref(bytes);
    wait_level(1);
    wb_read(REG_RX_DATA, rd);
    expect_eq("flush top byte", '0, rd[31:24]);
    expect_eq("flush word", words[0], rd);

    // Back-pressure until ready stays low
    bytes.delete();
    low_cnt   = 0;
    guard     = 0;
    rx_wvalid = 1'b1;
    rx_wdata  = rand_byte();
    while (low_cnt < 20) begin
      rdy = rx_wready;
      next_slot();
      guard++;
      if (guard > 3 * TIMEOUT) abort_run("timeout waiting for back-pressure");
      if (rdy) begin
        bytes.push_back(rx_wdata);
        rx_wdata = rand_byte();
        low_cnt  = 0;
      end else begin
        low_cnt++;
      end
    end
    rx_wvalid = 1'b0;
    expect_eq("backpressure byte count", (QUEUE_DEPTH + 1) * BYTES_PER_WORD, bytes.size());
    words = pack_ref(bytes);
    wb_read(REG_STATUS, rd);
    expect_eq("backpressure status", (1 << STAT_FULL) | (QUEUE_DEPTH << STAT_LEVEL_LSB), rd);
    foreach (words[i]) begin
      wb_read(REG_RX_DATA, rd);
      expect_eq($sformatf("backpressure drain %0d", i), words[i], rd);
    end

    // Threshold interrupt
    wb_write(REG_CTRL, 2 << CTRL_THLD_LSB);
    bytes.delete();
    send_random(4, bytes);
    wait_level(1);
    expect_eq("threshold irq one word", 0, irq);
    send_random(4, bytes);
    wait_level(2);
    expect_eq("threshold irq two words", 1, irq);
    words = pack_ref(bytes);
    wb_read(REG_RX_DATA, rd);
    expect_eq("threshold word 0", words[0], rd);
    expect_eq("threshold irq after read", 0, irq);
    wb_read(REG_RX_DATA, rd);
    expect_eq("threshold word 1", words[1], rd);
    wb_write(REG_CTRL, 0);

    // Recovery PEC
    wb_write(REG_CTRL, 1 << CTRL_REC_EN);
    n = int'(rand_byte() % 16) + 1;
    bytes.delete();
    bus_start = 1'b1;
    next_slot();
    bus_start = 1'b0;
    send_random(n, bytes);
    bus_stop = 1'b1;
    next_slot();
    bus_stop = 1'b0;
    wait_irq();
    wb_read(REG_STATUS, rd);
    expect_eq("pec status done", (1 << STAT_EMPTY) | (1 << STAT_PEC_DONE), rd);
    wb_read(REG_PEC, rd);
    expect_eq("pec value and count", (n << BYTE_W) | crc_ref(bytes), rd);
    wb_read(REG_STATUS, rd);
    expect_eq("pec status after read", 1 << STAT_EMPTY, rd);
    wb_write(REG_CTRL, 0);

    // Queue clear
    bytes.delete();
    send_random(8, bytes);
    wait_level(2);
    wb_write(REG_CTRL, 1 << CTRL_CLEAR);
    wb_read(REG_STATUS, rd);
    expect_eq("clear status", 1 << STAT_EMPTY, rd);

    guard = 0;
    while (chk_act.size() != 0) begin
      next_slot();
      guard++;
      if (guard > TIMEOUT) abort_run("timeout waiting for the checker to drain");
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- hw/recovery_handler.sv
// Receive side only; in recovery mode bytes are always accepted and flush has no effect
`timescale 1ns/10ps

module recovery_handler (
  input  logic                         clk_i,
  input  logic                         arst_n_i,

  // Controller byte stream
  input  logic                         ctl_rx_wvalid_i,
  input  logic [rec_pkg::BYTE_W-1:0]   ctl_rx_wdata_i,
  input  logic                         ctl_rx_wflush_i,
  output logic                         ctl_rx_wready_o,

  // Bus conditions
  input  logic                         ctl_bus_start_i,
  input  logic                         ctl_bus_stop_i,

  // Wishbone
  input  logic                         wb_cyc_i,
  input  logic                         wb_stb_i,
  input  logic                         wb_we_i,
  input  logic [rec_pkg::WB_ADR_W-1:0] wb_adr_i,
  input  logic [rec_pkg::WORD_W-1:0]   wb_dat_i,
  output logic [rec_pkg::WORD_W-1:0]   wb_dat_o,
  output logic                         wb_ack_o,

  output logic                         irq_o
);
  import rec_pkg::*;

  logic               pk_valid;
  logic               pk_flush;
  logic               pk_ready;
  logic               word_valid;
  logic               word_ready;
  logic [WORD_W-1:0]  word_data;
  logic [WORD_W-1:0]  q_rdata;
  logic [LEVEL_W-1:0] q_level;
  logic               q_empty;
  logic               q_full;
  logic               q_pop;
  logic               q_clear;
  logic               pec_byte_valid;
  logic               pec_ack;
  logic [BYTE_W-1:0]  pec_value;
  logic [CNT_W-1:0]   pec_count;
  logic               pec_done;

  rx_byte_packer u_packer (
    .clk_i,
    .arst_n_i,
    .byte_valid_i (pk_valid),
    .byte_flush_i (pk_flush),
    .clear_i      (q_clear),
    .byte_data_i  (ctl_rx_wdata_i),
    .byte_ready_o (pk_ready),
    .word_valid_o (word_valid),
    .word_data_o  (word_data),
    .word_ready_i (word_ready)
  );

  rx_data_queue u_queue (
    .clk_i,
    .arst_n_i,
    .wvalid_i (word_valid),
    .pop_i    (q_pop),
    .clear_i  (q_clear),
    .wdata_i  (word_data),
    .wready_o (word_ready),
    .empty_o  (q_empty),
    .full_o   (q_full),
    .rdata_o  (q_rdata),
    .level_o  (q_level)
  );

  recovery_pec u_pec (
    .clk_i,
    .arst_n_i,
    .bus_start_i  (ctl_bus_start_i),
    .bus_stop_i   (ctl_bus_stop_i),
    .byte_valid_i (pec_byte_valid),
    .ack_i        (pec_ack),
    .byte_data_i  (ctl_rx_wdata_i),
    .pec_o        (pec_value),
    .count_o      (pec_count),
    .done_o       (pec_done)
  );

  rec_csr_wb u_csr (
    .clk_i,
    .arst_n_i,
    .ctl_wvalid_i     (ctl_rx_wvalid_i),
    .ctl_wflush_i     (ctl_rx_wflush_i),
    .ctl_wready_o     (ctl_rx_wready_o),
    .pk_valid_o       (pk_valid),
    .pk_flush_o       (pk_flush),
    .pk_ready_i       (pk_ready),
    .pec_byte_valid_o (pec_byte_valid),
    .pec_ack_o        (pec_ack),
    .pec_i            (pec_value),
    .pec_count_i      (pec_count),
    .pec_done_i       (pec_done),
    .q_rdata_i        (q_rdata),
    .q_level_i        (q_level),
    .q_empty_i        (q_empty),
    .q_full_i         (q_full),
    .q_pop_o          (q_pop),
    .q_clear_o        (q_clear),
    .wb_cyc_i,
    .wb_stb_i,
    .wb_we_i,
    .wb_adr_i,
    .wb_dat_i,
    .wb_dat_o,
    .wb_ack_o,
    .irq_o
  );

endmodule

//--- hw/rec_csr_wb.sv
// Wishbone classic slave with one-cycle ack; master must drop stb in the cycle after ack
`timescale 1ns/10ps

module rec_csr_wb (
  input  logic                         clk_i,
  input  logic                         arst_n_i,

  // Controller byte stream
  input  logic                         ctl_wvalid_i,
  input  logic                         ctl_wflush_i,
  output logic                         ctl_wready_o,

  // Packer
  output logic                         pk_valid_o,
  output logic                         pk_flush_o,
  input  logic                         pk_ready_i,

  // PEC calculator
  output logic                         pec_byte_valid_o,
  output logic                         pec_ack_o,
  input  logic [rec_pkg::BYTE_W-1:0]   pec_i,
  input  logic [rec_pkg::CNT_W-1:0]    pec_count_i,
  input  logic                         pec_done_i,

  // RX data queue
  input  logic [rec_pkg::WORD_W-1:0]   q_rdata_i,
  input  logic [rec_pkg::LEVEL_W-1:0]  q_level_i,
  input  logic                         q_empty_i,
  input  logic                         q_full_i,
  output logic                         q_pop_o,
  output logic                         q_clear_o,

  // Wishbone
  input  logic                         wb_cyc_i,
  input  logic                         wb_stb_i,
  input  logic                         wb_we_i,
  input  logic [rec_pkg::WB_ADR_W-1:0] wb_adr_i,
  input  logic [rec_pkg::WORD_W-1:0]   wb_dat_i,
  output logic [rec_pkg::WORD_W-1:0]   wb_dat_o,
  output logic                         wb_ack_o,

  output logic                         irq_o
);
  import rec_pkg::*;

  logic               rec_en_q;
  logic [LEVEL_W-1:0] thld_q;
  logic               ack_q;
  logic               pop_q;
  logic               clear_q;
  logic               pec_ack_q;
  logic               wb_req;
  logic               rd_req;
  logic               wr_req;
  csr_addr_e          addr;
  logic [WORD_W-1:0]  rdata;

  // Byte steering by mode; data goes to both sides as is
  assign pk_valid_o       = !rec_en_q && ctl_wvalid_i;
  assign pk_flush_o       = !rec_en_q && ctl_wflush_i;
  assign pec_byte_valid_o = rec_en_q && ctl_wvalid_i;
  assign ctl_wready_o     = rec_en_q || pk_ready_i;

  assign addr   = csr_addr_e'(wb_adr_i);
  assign wb_req = wb_cyc_i && wb_stb_i && !ack_q;
  assign rd_req = wb_req && !wb_we_i;
  assign wr_req = wb_req && wb_we_i;

  always_comb begin
    rdata = '0;
    case (addr)
      REG_CTRL: begin
        rdata[0]   = rec_en_q;
        rdata[7:4] = thld_q;
      end
      REG_STATUS: begin
        rdata[0]   = q_empty_i;
        rdata[1]   = q_full_i;
        rdata[7:4] = q_level_i;
        rdata[8]   = pec_done_i;
      end
      // Empty queue reads as zero
      REG_RX_DATA: rdata = q_empty_i ? '0 : q_rdata_i;
      REG_PEC: begin
        rdata[7:0]  = pec_i;
        rdata[15:8] = pec_count_i;
      end
      default: rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rec_en_q  <= 1'b0;
      thld_q    <= '0;
      ack_q     <= 1'b0;
      pop_q     <= 1'b0;
      clear_q   <= 1'b0;
      pec_ack_q <= 1'b0;
    end else begin
      ack_q     <= wb_req;
      pop_q     <= rd_req && (addr == REG_RX_DATA) && !q_empty_i;
      pec_ack_q <= rd_req && (addr == REG_PEC);
      clear_q   <= wr_req && (addr == REG_CTRL) && wb_dat_i[8];
      if (wr_req && (addr == REG_CTRL)) begin
        rec_en_q <= wb_dat_i[0];
        thld_q   <= wb_dat_i[7:4];
      end
    end
  end

  // Read data captured with the request, valid during ack
  always_ff @(posedge clk_i) begin
    if (wb_req) begin
      wb_dat_o <= rdata;
    end
  end

  assign wb_ack_o  = ack_q;
  assign q_pop_o   = pop_q;
  assign q_clear_o = clear_q;
  assign pec_ack_o = pec_ack_q;

  assign irq_o = ((thld_q != '0) && (q_level_i >= thld_q)) || pec_done_i;

  a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_ack_o |-> (wb_cyc_i && wb_stb_i))
    else $error("wishbone ack outside an active cycle");

endmodule

//--- hw/recovery_pec.sv
// Start wins over a byte in the same cycle; a byte that comes with stop is still counted
`timescale 1ns/10ps

module recovery_pec (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       bus_start_i,
  input  logic                       bus_stop_i,
  input  logic                       byte_valid_i,
  input  logic                       ack_i,
  input  logic [rec_pkg::BYTE_W-1:0] byte_data_i,
  output logic [rec_pkg::BYTE_W-1:0] pec_o,
  output logic [rec_pkg::CNT_W-1:0]  count_o,
  output logic                       done_o
);
  import rec_pkg::*;

  frame_state_e      state_q;
  logic [BYTE_W-1:0] crc_q;
  logic [CNT_W-1:0]  cnt_q;

  // One byte through the CRC-8, MSB first
  function automatic logic [BYTE_W-1:0] crc8_next(logic [BYTE_W-1:0] crc,
                                                  logic [BYTE_W-1:0] data);
    logic [BYTE_W-1:0] c;
    c = crc ^ data;
    for (int b = 0; b < BYTE_W; b++) begin
      c = c[BYTE_W-1] ? ((c << 1) ^ PEC_POLY) : (c << 1);
    end
    return c;
  endfunction

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= FRAME_IDLE;
      crc_q   <= '0;
      cnt_q   <= '0;
    end else if (bus_start_i) begin
      state_q <= FRAME_ACTIVE;
      crc_q   <= '0;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        FRAME_ACTIVE: begin
          if (byte_valid_i) begin
            crc_q <= crc8_next(crc_q, byte_data_i);
            if (cnt_q != '1) begin
              cnt_q <= cnt_q + 1'b1;
            end
          end
          if (bus_stop_i) begin
            state_q <= FRAME_DONE;
          end
        end
        // Result held until the CSR side reads it
        FRAME_DONE: if (ack_i) state_q <= FRAME_IDLE;
        default:    state_q <= state_q;
      endcase
    end
  end

  assign pec_o   = crc_q;
  assign count_o = cnt_q;
  assign done_o  = (state_q == FRAME_DONE);

  a_start_stop_apart: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(bus_start_i && bus_stop_i))
    else $error("bus start and stop in the same cycle");

endmodule

//--- hw/rx_data_queue.sv
// Word FIFO; a write into a full queue is refused even when a pop happens in the same cycle
`timescale 1ns/10ps

module rx_data_queue (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        wvalid_i,
  input  logic                        pop_i,
  input  logic                        clear_i,
  input  logic [rec_pkg::WORD_W-1:0]  wdata_i,
  output logic                        wready_o,
  output logic                        empty_o,
  output logic                        full_o,
  output logic [rec_pkg::WORD_W-1:0]  rdata_o,
  output logic [rec_pkg::LEVEL_W-1:0] level_o
);
  import rec_pkg::*;

  logic [WORD_W-1:0]              mem_q [QUEUE_DEPTH];
  logic [$clog2(QUEUE_DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(QUEUE_DEPTH)-1:0] rd_ptr_q;
  logic [LEVEL_W-1:0]             level_q;
  logic                           push;
  logic                           pop;

  assign full_o   = (level_q == LEVEL_W'(QUEUE_DEPTH));
  assign empty_o  = (level_q == '0);
  assign wready_o = !full_o;
  assign push     = wvalid_i && wready_o;
  assign pop      = pop_i && !empty_o;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  // Pointers wrap naturally on a power-of-two depth
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
    end
  end

  // Head word
  assign rdata_o = mem_q[rd_ptr_q];
  assign level_o = level_q;

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pop_i |-> !empty_o)
    else $error("queue popped while empty");

  a_level_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    level_q <= LEVEL_W'(QUEUE_DEPTH))
    else $error("queue level above depth");

endmodule

//--- hw/rx_byte_packer.sv
// Packs LSB first; a flush with no held byte is dropped, a flush while a word waits is ignored
`timescale 1ns/10ps

module rx_byte_packer (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        byte_valid_i,
  input  logic                        byte_flush_i,
  input  logic                        clear_i,
  input  logic [rec_pkg::BYTE_W-1:0]  byte_data_i,
  output logic                        byte_ready_o,
  output logic                        word_valid_o,
  output logic [rec_pkg::WORD_W-1:0]  word_data_o,
  input  logic                        word_ready_i
);
  import rec_pkg::*;

  logic [WORD_W-1:0]                   word_q;
  logic [$clog2(BYTES_PER_WORD+1)-1:0] cnt_q;
  logic                                word_valid_q;
  logic                                accept;
  logic                                flush_take;
  logic                                word_take;
  logic                                last_byte;

  // Input stalls while a word waits for the queue
  assign byte_ready_o = !word_valid_q;
  assign accept       = byte_valid_i && byte_ready_o;
  assign flush_take   = byte_flush_i && byte_ready_o;
  assign word_take    = word_valid_q && word_ready_i;
  assign last_byte    = accept && (cnt_q == BYTES_PER_WORD - 1);

  always_ff @(posedge clk_i) begin
    if (accept) begin
      word_q[cnt_q*BYTE_W +: BYTE_W] <= byte_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q        <= '0;
      word_valid_q <= 1'b0;
    end else if (clear_i) begin
      cnt_q        <= '0;
      word_valid_q <= 1'b0;
    end else if (word_take) begin
      cnt_q        <= '0;
      word_valid_q <= 1'b0;
    end else begin
      if (accept) begin
        cnt_q <= cnt_q + 1'b1;
      end
      if (last_byte || (flush_take && (accept || cnt_q != '0))) begin
        word_valid_q <= 1'b1;
      end
    end
  end

  // Bytes not yet written read as zero
  always_comb begin
    for (int i = 0; i < BYTES_PER_WORD; i++) begin
      word_data_o[i*BYTE_W +: BYTE_W] = (i < cnt_q) ? word_q[i*BYTE_W +: BYTE_W] : '0;
    end
  end

  assign word_valid_o = word_valid_q;

  a_word_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (word_valid_o && !word_ready_i && !clear_i) |=> $stable(word_data_o))
    else $error("packer word changed while waiting");

endmodule

//--- hw/rec_pkg.sv
// Shared widths and encodings; QUEUE_DEPTH must be a power of two and fit in LEVEL_W
package rec_pkg;

  // Bus byte and queue word
  localparam int unsigned BYTE_W = 8;
  localparam int unsigned WORD_W = 32;
  localparam int unsigned BYTES_PER_WORD = WORD_W / BYTE_W;

  // RX data queue
  localparam int unsigned QUEUE_DEPTH = 8;
  localparam int unsigned LEVEL_W = 4;

  // SMBus PEC, CRC-8 from zero, MSB first
  localparam logic [BYTE_W-1:0] PEC_POLY = 8'h07;

  // Frame byte counter, saturating
  localparam int unsigned CNT_W = 8;

  // Wishbone word address
  localparam int unsigned WB_ADR_W = 2;

  typedef enum logic [WB_ADR_W-1:0] {
    REG_CTRL    = 2'd0,
    REG_STATUS  = 2'd1,
    REG_RX_DATA = 2'd2,
    REG_PEC     = 2'd3
  } csr_addr_e;

  typedef enum logic [1:0] {
    FRAME_IDLE   = 2'd0,
    FRAME_ACTIVE = 2'd1,
    FRAME_DONE   = 2'd2
  } frame_state_e;

endpackage
